// File: hdl/jumpCfg_cfg.svh
`ifndef JUMPCFG_CFG_SVH
`define JUMPCFG_CFG_SVH

// visible area in pixels
`define SCREEN_X_MAX 639
`define SCREEN_Y_MAX 479

`define DOODLE_SIZE 16 // half-extent of the doodle
`define START_X 330
`define START_Y 100

// bounce strengths, pixels per frame upward
`define GRAVITY_BOOST 3
`define SPRING_BOOST 7
`define ROCKET_BOOST 15

`define MAX_FALL 10 // terminal fall speed
`define RAMP_PERIOD 4 // frames per velocity step
`define STEP_X 4 // sideways step per frame

// wrap-around at the side edges
`define WRAP_MARGIN 25
`define WRAP_OFFSET 128 // eight doodle sizes

`define SCORE_LINE 240
`define SCORE_LIMIT 256 // above this the floor is fatal

// object counts
`define NUM_PLATS 16
`define NUM_SPRINGS 4
`define NUM_ROCKETS 1

// object half sizes
`define PLAT_HALF_W 20
`define PLAT_HALF_H 4
`define SPRING_HALF_W 6
`define SPRING_HALF_H 4
`define ROCKET_HALF_W 8
`define ROCKET_HALF_H 12

// keyboard scan codes
`define KEY_RIGHT_A 7
`define KEY_RIGHT_B 79
`define KEY_LEFT_A 4
`define KEY_LEFT_B 80

`endif

// File: hdl/jumpPkg.sv
package jumpPkg;

	// screen coordinate in pixels
	typedef logic [9:0] coordT;

	// vertical speed, negative is upward
	typedef logic signed [7:0] velT;

	typedef logic [7:0] keyT; // keyboard scan code

	typedef logic [19:0] scoreT;

	// centre point of a platform, spring or rocket
	typedef struct packed
	{
		coordT x;
		coordT y;
	} boxT;

endpackage

// File: hdl/kinematicIf.sv
`timescale 1ns/100ps

interface kinematicIf;

	jumpPkg::coordT posX; // doodle centre
	jumpPkg::coordT posY;
	jumpPkg::velT motionY; // pixels per frame
	logic gameOver; // sticky until reset

	// velocity engine
	modport physics
	(
		output motionY,
		output gameOver,
		input posX,
		input posY
	);

	// integrates motion into a position
	modport position
	(
		output posX,
		output posY,
		input motionY,
		input gameOver
	);

endinterface

// File: hdl/boxHitDetect.sv
`timescale 1ns/100ps
`include "jumpCfg_cfg.svh"

module boxHitDetect #(
	parameter int NUM_OBJ = 1,
	parameter int HALF_W = 1,
	parameter int HALF_H = 1
) (
	input logic Reset,
	input jumpPkg::coordT posX,
	input jumpPkg::coordT posY,
	input jumpPkg::boxT objects [NUM_OBJ],
	output logic hit
);

	// 12 bits leave headroom for every sum below
	logic [11:0] feetY;
	logic [11:0] doodleLeft;
	logic [11:0] doodleRight;
	logic [NUM_OBJ-1:0] objHit;

	assign feetY = 12'(posY) + 12'(`DOODLE_SIZE);
	assign doodleLeft = 12'(posX); // left edge still carries +DOODLE_SIZE, see below
	assign doodleRight = 12'(posX) + 12'(`DOODLE_SIZE);

	// the subtractions of the overlap test are moved to the other side,
	// so no term can underflow near the top or left edge
	genvar i;
	generate
		for (i = 0; i < NUM_OBJ; i++)
		begin : gObj
			logic [11:0] objX;
			logic [11:0] objY;
			logic feetInRow;
			logic spanMeets;

			assign objX = 12'(objects[i].x);
			assign objY = 12'(objects[i].y);

			// feet row inside y +/- half height
			assign feetInRow = (feetY + 12'(HALF_H) >= objY) &&
				(feetY <= objY + 12'(HALF_H));

			// x +/- half width meets posX +/- DOODLE_SIZE
			assign spanMeets = (objX + 12'(HALF_W) + 12'(`DOODLE_SIZE) >= doodleLeft) &&
				(objX <= doodleRight + 12'(HALF_W));

			assign objHit[i] = feetInRow && spanMeets;
		end
	endgenerate

	assign hit = |objHit;

	// a known doodle over known boxes never yields an unknown hit
	aHitKnown : assert property (@(posedge Reset)
		!$isunknown({posX, posY}) && !$isunknown(objects.sum() with (32'(item))) |->
		!$isunknown(hit))
		else $error("hit unknown with known position");

endmodule

// File: hdl/jumpPhysics.sv
`timescale 1ns/100ps
`include "jumpCfg_cfg.svh"

module jumpPhysics (
	input logic Reset,
	input logic frame_clk,
	input logic paused,
	input logic platHit,
	input logic springHit,
	input logic rocketHit,
	input logic scoreHigh,
	kinematicIf.physics kin
);

	localparam int RampW = $clog2(`RAMP_PERIOD);

	localparam jumpPkg::velT FallStart = jumpPkg::velT'(`GRAVITY_BOOST);
	localparam jumpPkg::velT FallMax = jumpPkg::velT'(`MAX_FALL);
	localparam jumpPkg::velT GravityUp = jumpPkg::velT'(-(`GRAVITY_BOOST));
	localparam jumpPkg::velT SpringUp = jumpPkg::velT'(-(`SPRING_BOOST));
	localparam jumpPkg::velT RocketUp = jumpPkg::velT'(-(`ROCKET_BOOST));

	logic [RampW-1:0] rampCnt; // frames since the last velocity step
	logic [10:0] feetY;
	logic onFloor;
	logic falling;
	logic rampTick;
	logic bounce;
	jumpPkg::velT bounceVel;
	jumpPkg::velT rampMotion;

	assign feetY = 11'(kin.posY) + 11'(`DOODLE_SIZE);
	assign onFloor = feetY >= 11'(`SCREEN_Y_MAX);
	assign falling = kin.motionY > 0;
	assign rampTick = rampCnt == RampW'(`RAMP_PERIOD - 1);

	// gravity pulls one step down per ramp period, capped at terminal speed
	assign rampMotion = (rampTick && kin.motionY < FallMax) ?
		kin.motionY + jumpPkg::velT'(1) : kin.motionY;

	// landing strength, spring first, then rocket, platform and floor
	always_comb
	begin
		bounce = 1'b1;
		if (springHit)
			bounceVel = SpringUp;
		else if (rocketHit)
			bounceVel = RocketUp;
		else if (platHit)
			bounceVel = GravityUp;
		else if (onFloor && !scoreHigh)
			bounceVel = GravityUp; // floor is still safe
		else
		begin
			bounce = 1'b0;
			bounceVel = GravityUp;
		end
	end

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			kin.motionY <= '0;
			kin.gameOver <= 1'b0;
			rampCnt <= '0;
		end
		else if (paused || kin.gameOver)
			kin.motionY <= '0; // frozen play
		else if (kin.motionY == 0)
		begin
			kin.motionY <= FallStart; // apex, start the fall
			rampCnt <= '0;
		end
		else if (falling && bounce)
		begin
			kin.motionY <= bounceVel;
			rampCnt <= '0;
		end
		else if (falling && onFloor)
		begin
			// floor hit with a high score ends the game
			kin.gameOver <= 1'b1;
			kin.motionY <= '0;
		end
		else
		begin
			kin.motionY <= rampMotion;
			rampCnt <= rampTick ? '0 : rampCnt + 1'b1;
		end
	end

	aMotionRange : assert property (@(posedge Reset) disable iff (frame_clk)
		kin.motionY >= -(`ROCKET_BOOST) && kin.motionY <= `MAX_FALL)
		else $error("motionY out of range: %0d", kin.motionY);

	// only reset may clear game over
	aOverSticky : assert property (@(posedge Reset) disable iff (frame_clk)
		kin.gameOver |=> kin.gameOver)
		else $error("gameOver fell without reset");

endmodule

// File: hdl/doodlePosition.sv
`timescale 1ns/100ps
`include "jumpCfg_cfg.svh"

module doodlePosition (
	input logic Reset,
	input logic frame_clk,
	input logic paused,
	input jumpPkg::keyT keycode,
	kinematicIf.position kin,
	output jumpPkg::scoreT score,
	output logic scoreHigh
);

	localparam int VelW = $bits(jumpPkg::velT);
	localparam int ExtW = $bits(jumpPkg::coordT) - VelW;

	jumpPkg::coordT stepX;
	jumpPkg::coordT deltaY;
	jumpPkg::scoreT gain;
	logic wrapRight;
	logic wrapLeft;
	logic aboveLine;
	logic frozen;

	// sign-extended vertical motion
	assign deltaY = {{ExtW{kin.motionY[VelW-1]}}, kin.motionY};

	always_comb
	begin
		case (keycode)
			`KEY_RIGHT_A, `KEY_RIGHT_B:
				stepX = jumpPkg::coordT'(`STEP_X);
			`KEY_LEFT_A, `KEY_LEFT_B:
				stepX = jumpPkg::coordT'(-(`STEP_X)); // two's complement step
			default:
				stepX = '0;
		endcase
	end

	assign wrapRight = 11'(kin.posX) + 11'(`DOODLE_SIZE) >=
		11'(`SCREEN_X_MAX - `WRAP_MARGIN);
	// posX - DOODLE_SIZE <= WRAP_MARGIN, rearranged to stay unsigned
	assign wrapLeft = kin.posX <= jumpPkg::coordT'(`WRAP_MARGIN + `DOODLE_SIZE);

	assign aboveLine = kin.posY < jumpPkg::coordT'(`SCORE_LINE);
	assign gain = jumpPkg::scoreT'(jumpPkg::coordT'(`SCORE_LINE) - kin.posY);

	assign frozen = paused || kin.gameOver;
	assign scoreHigh = score > jumpPkg::scoreT'(`SCORE_LIMIT);

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			kin.posX <= jumpPkg::coordT'(`START_X);
			kin.posY <= jumpPkg::coordT'(`START_Y);
			score <= '0;
		end
		else if (!frozen)
		begin
			kin.posY <= kin.posY + deltaY;

			// edge wrap wins over steering
			if (wrapRight)
				kin.posX <= jumpPkg::coordT'(`WRAP_OFFSET);
			else if (wrapLeft)
				kin.posX <= jumpPkg::coordT'(`SCREEN_X_MAX - `WRAP_OFFSET);
			else
				kin.posX <= kin.posX + stepX;

			if (aboveLine)
				score <= score + gain; // height above the score line
		end
	end

	aPosXOnScreen : assert property (@(posedge Reset) disable iff (frame_clk)
		kin.posX <= jumpPkg::coordT'(`SCREEN_X_MAX))
		else $error("posX left the screen: %0d", kin.posX);

endmodule

// File: hdl/jumpLogic.sv
`timescale 1ns/100ps
`include "jumpCfg_cfg.svh"

module jumpLogic (
	input logic Reset, // frame clock
	input logic frame_clk, // async reset, active high
	input logic paused,
	input jumpPkg::keyT keycode,
	input jumpPkg::boxT platforms [`NUM_PLATS],
	input jumpPkg::boxT springs [`NUM_SPRINGS],
	input jumpPkg::boxT rockets [`NUM_ROCKETS],
	output jumpPkg::coordT doodleX,
	output jumpPkg::coordT doodleY,
	output jumpPkg::velT doodleMotionY,
	output jumpPkg::scoreT score,
	output logic gameOver,
	output logic platHit,
	output logic springHit,
	output logic rocketHit
);

	logic scoreHigh;

	kinematicIf kin ();

	assign doodleX = kin.posX;
	assign doodleY = kin.posY;
	assign doodleMotionY = kin.motionY;
	assign gameOver = kin.gameOver;

	boxHitDetect #(
		.NUM_OBJ(`NUM_PLATS),
		.HALF_W(`PLAT_HALF_W),
		.HALF_H(`PLAT_HALF_H)
	) platDetect (
		.Reset(Reset),
		.posX(doodleX),
		.posY(doodleY),
		.objects(platforms),
		.hit(platHit)
	);

	boxHitDetect #(
		.NUM_OBJ(`NUM_SPRINGS),
		.HALF_W(`SPRING_HALF_W),
		.HALF_H(`SPRING_HALF_H)
	) springDetect (
		.Reset(Reset),
		.posX(doodleX),
		.posY(doodleY),
		.objects(springs),
		.hit(springHit)
	);

	boxHitDetect #(
		.NUM_OBJ(`NUM_ROCKETS),
		.HALF_W(`ROCKET_HALF_W),
		.HALF_H(`ROCKET_HALF_H)
	) rocketDetect (
		.Reset(Reset),
		.posX(doodleX),
		.posY(doodleY),
		.objects(rockets),
		.hit(rocketHit)
	);

	jumpPhysics physics (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.paused(paused),
		.platHit(platHit),
		.springHit(springHit),
		.rocketHit(rocketHit),
		.scoreHigh(scoreHigh),
		.kin(kin.physics)
	);

	doodlePosition position (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.paused(paused),
		.keycode(keycode),
		.kin(kin.position),
		.score(score),
		.scoreHigh(scoreHigh)
	);

endmodule

// File: sim/frameClockGen.sv
`timescale 1ns/100ps

module frameClockGen #(
	parameter int HalfPeriod = 50,
	parameter int ResetCycles = 10
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#HalfPeriod clk = ~clk;
	end

	// reset released shortly after an edge, like any other input
	initial
	begin
		rst = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		#10 rst = 1'b0;
	end

endmodule

// File: sim/jumpLogicTb.sv
`timescale 1ns/100ps
`include "jumpCfg_cfg.svh"

module jumpLogicTb;

	// frame budget of all tests, the timeout adds half of it on top
	localparam int TestFrames = 40 + 300 + 30 + 4 * 340 + 900 + 20;
	localparam int CycleLimit = TestFrames + TestFrames / 2;

	logic Reset; // frame clock
	logic frame_clk; // reset
	logic paused;
	jumpPkg::keyT keycode;
	jumpPkg::boxT platforms [`NUM_PLATS];
	jumpPkg::boxT springs [`NUM_SPRINGS];
	jumpPkg::boxT rockets [`NUM_ROCKETS];
	jumpPkg::coordT doodleX;
	jumpPkg::coordT doodleY;
	jumpPkg::velT doodleMotionY;
	jumpPkg::scoreT score;
	logic gameOver;
	logic platHit;
	logic springHit;
	logic rocketHit;

	// reference state built from the game rules
	jumpPkg::coordT mX;
	jumpPkg::coordT mY;
	jumpPkg::velT mV;
	jumpPkg::scoreT mScore;
	logic mOver;
	int mRamp;
	logic expPlat;
	logic expSpring;
	logic expRocket;

	int errors = 0;
	int cycles = 0;
	int seed = 36;

	frameClockGen clockGen (.clk(Reset), .rst(frame_clk));

	jumpLogic uut (.*);

	function automatic logic overlaps(int x, int y, jumpPkg::boxT b, int hw, int hh);
		int feet;
		int dx;
		int dy;
		feet = y + `DOODLE_SIZE;
		dy = feet - int'(b.y);
		dx = int'(b.x) - x;
		return (dy <= hh && dy >= -hh) &&
			(dx <= hw + `DOODLE_SIZE && dx >= -(hw + `DOODLE_SIZE));
	endfunction

	// expected hits from the reference position
	always_comb
	begin
		expPlat = 1'b0;
		expSpring = 1'b0;
		expRocket = 1'b0;
		foreach (platforms[i])
			expPlat |= overlaps(mX, mY, platforms[i], `PLAT_HALF_W, `PLAT_HALF_H);
		foreach (springs[i])
			expSpring |= overlaps(mX, mY, springs[i], `SPRING_HALF_W, `SPRING_HALF_H);
		foreach (rockets[i])
			expRocket |= overlaps(mX, mY, rockets[i], `ROCKET_HALF_W, `ROCKET_HALF_H);
	end

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			mX <= `START_X;
			mY <= `START_Y;
			mV <= 0;
			mScore <= 0;
			mOver <= 1'b0;
			mRamp <= 0;
		end
		else if (paused || mOver)
			mV <= 0;
		else
		begin
			mY <= mY + jumpPkg::coordT'(int'(mV)); // wraps modulo the coordinate width
			if (int'(mX) + `DOODLE_SIZE >= `SCREEN_X_MAX - `WRAP_MARGIN)
				mX <= `WRAP_OFFSET;
			else if (int'(mX) - `DOODLE_SIZE <= `WRAP_MARGIN)
				mX <= `SCREEN_X_MAX - `WRAP_OFFSET;
			else if (keycode == `KEY_RIGHT_A || keycode == `KEY_RIGHT_B)
				mX <= mX + `STEP_X;
			else if (keycode == `KEY_LEFT_A || keycode == `KEY_LEFT_B)
				mX <= mX - `STEP_X;
			if (mY < `SCORE_LINE)
				mScore <= mScore + (`SCORE_LINE - mY);

			if (mV == 0)
			begin
				mV <= `GRAVITY_BOOST; // apex
				mRamp <= 0;
			end
			else if (mV > 0 && (expSpring || expRocket || expPlat ||
				int'(mY) + `DOODLE_SIZE >= `SCREEN_Y_MAX))
			begin
				mRamp <= 0;
				if (expSpring)
					mV <= -(`SPRING_BOOST);
				else if (expRocket)
					mV <= -(`ROCKET_BOOST);
				else if (expPlat || mScore <= `SCORE_LIMIT)
					mV <= -(`GRAVITY_BOOST);
				else
				begin
					mOver <= 1'b1; // floor with a high score
					mV <= 0;
				end
			end
			else if (mRamp == `RAMP_PERIOD - 1)
			begin
				mRamp <= 0;
				if (mV < `MAX_FALL)
					mV <= mV + 1;
			end
			else
				mRamp <= mRamp + 1;
		end
	end

	aDoodleX : assert property (@(posedge Reset) disable iff (frame_clk) doodleX == mX)
		else
		begin
			errors++;
			$display("[FAIL] doodleX got %h expected %h", $sampled(doodleX), $sampled(mX));
		end

	aDoodleY : assert property (@(posedge Reset) disable iff (frame_clk) doodleY == mY)
		else
		begin
			errors++;
			$display("[FAIL] doodleY got %h expected %h", $sampled(doodleY), $sampled(mY));
		end

	aMotion : assert property (@(posedge Reset) disable iff (frame_clk) doodleMotionY == mV)
		else
		begin
			errors++;
			$display("[FAIL] doodleMotionY got %h expected %h",
				$sampled(doodleMotionY), $sampled(mV));
		end

	aScore : assert property (@(posedge Reset) disable iff (frame_clk) score == mScore)
		else
		begin
			errors++;
			$display("[FAIL] score got %h expected %h", $sampled(score), $sampled(mScore));
		end

	aOver : assert property (@(posedge Reset) disable iff (frame_clk) gameOver == mOver)
		else
		begin
			errors++;
			$display("[FAIL] gameOver got %h expected %h", $sampled(gameOver), $sampled(mOver));
		end

	// hits are combinational, so compare them in the same frame
	aHits : assert property (@(posedge Reset) disable iff (frame_clk)
		{platHit, springHit, rocketHit} == {expPlat, expSpring, expRocket})
		else
		begin
			errors++;
			$display("[FAIL] platHit/springHit/rocketHit got %h expected %h",
				$sampled({platHit, springHit, rocketHit}),
				$sampled({expPlat, expSpring, expRocket}));
		end

	always @(posedge Reset)
	begin
		cycles++;
		if (cycles >= CycleLimit)
		begin
			$display("timeout: the run went past %0d frames without finishing", CycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic nextFrame();
		@(posedge Reset);
		#10;
	endtask

	task automatic clearBoxes();
		foreach (platforms[i])
			platforms[i] = '0;
		foreach (springs[i])
			springs[i] = '0;
		foreach (rockets[i])
			rockets[i] = '0;
	endtask

	// parks platform 0 under a doodle that falls towards the floor
	task automatic catchAboveFloor();
		if (doodleMotionY > 0 && int'(doodleY) + `DOODLE_SIZE >= 400 &&
			int'(doodleY) + `DOODLE_SIZE < `SCREEN_Y_MAX)
		begin
			platforms[0].x = doodleX;
			platforms[0].y = doodleY + jumpPkg::coordT'(`DOODLE_SIZE);
		end
		else
			platforms[0] = '0;
	endtask

	// frames that keep the doodle off the floor
	task automatic guardedFrames(int count);
		repeat (count)
		begin
			catchAboveFloor();
			nextFrame();
		end
	endtask

	task automatic reportTest(string name, int errBefore);
		if (errors == errBefore)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errBefore);
	endtask

	// waits for a fall well above the floor, then puts one box under the feet
	task automatic bounceOn(int kind);
		int n;
		jumpPkg::boxT b;
		n = 0;
		while (!(doodleMotionY > 0 && doodleY < 400) && n < 300)
		begin
			catchAboveFloor();
			nextFrame();
			n++;
		end
		if (n >= 300)
		begin
			errors++;
			$display("doodle never fell clear of the floor for a bounce");
		end
		clearBoxes();
		b.x = doodleX;
		b.y = doodleY + `DOODLE_SIZE;
		if (kind == 0)
			platforms[3] = b;
		else if (kind == 1)
			springs[1] = b;
		else if (kind == 2)
			rockets[0] = b;
		else
		begin
			springs[2] = b; // spring and rocket together
			rockets[0] = b;
		end
		nextFrame();
		clearBoxes();
		guardedFrames(30);
	endtask

	initial
	begin
		int errBefore;
		int n;
		paused = 1'b0;
		keycode = '0;
		clearBoxes();
		@(negedge frame_clk);
		#1;

		errBefore = errors;
		repeat (40) nextFrame();
		reportTest("reset and apex", errBefore);

		errBefore = errors;
		for (n = 0; n < 300; n++)
		begin
			if (n < 120)
				keycode = (n % 2) ? `KEY_RIGHT_A : `KEY_RIGHT_B;
			else if (n < 240)
				keycode = (n % 2) ? `KEY_LEFT_A : `KEY_LEFT_B;
			else
				keycode = jumpPkg::keyT'($random(seed));
			// platform 0 stays free for the floor catch
			platforms[1 + n % (`NUM_PLATS - 1)].x =
				jumpPkg::coordT'($unsigned($random(seed)) % 640);
			platforms[1 + n % (`NUM_PLATS - 1)].y =
				jumpPkg::coordT'($unsigned($random(seed)) % 480);
			catchAboveFloor();
			nextFrame();
		end
		keycode = '0;
		clearBoxes();
		reportTest("steering and wrap", errBefore);

		errBefore = errors;
		paused = 1'b1;
		keycode = `KEY_RIGHT_A;
		repeat (20) nextFrame();
		paused = 1'b0;
		keycode = '0;
		guardedFrames(10);
		reportTest("pause", errBefore);

		errBefore = errors;
		bounceOn(0);
		bounceOn(1);
		bounceOn(3);
		reportTest("bounces", errBefore);

		errBefore = errors;
		bounceOn(2); // rocket lifts the doodle over the score line
		n = 0;
		while (!gameOver && n < 900)
		begin
			nextFrame();
			n++;
		end
		if (!gameOver)
		begin
			errors++;
			$display("gameOver never rose after the score passed the limit");
		end
		keycode = `KEY_LEFT_A;
		repeat (20) nextFrame();
		reportTest("score and game over", errBefore);

		$display("checks done after %0d frames, %0d errors", cycles, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+hdl
hdl/jumpPkg.sv
hdl/kinematicIf.sv
hdl/boxHitDetect.sv
hdl/jumpPhysics.sv
hdl/doodlePosition.sv
hdl/jumpLogic.sv
sim/frameClockGen.sv
sim/jumpLogicTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall
TOP       ?= jumpLogicTb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module jumpLogic -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
